// ==== ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ------------------------------------------------------------
// execute stage widths
// ------------------------------------------------------------

// data and address width
`define EX_XLEN 32

// register file address
`define EX_REG_AW 5

// load/store function code
`define EX_FUNCT3_W 3

// instruction size in halfwords (1 = compressed, 2 = full)
`define EX_INS_SIZE_W 2

`endif

// ==== ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // branch compare, same codes as the branch funct3 field
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    // result destination
    typedef enum logic [1:0] {
        ZONE_NONE,
        ZONE_REGFILE,
        ZONE_LOADQ,
        ZONE_STOREQ
    } zone_e;

    // fetch path tag
    typedef enum logic {
        SOFID_RUN  = 1'b0,
        SOFID_JUMP = 1'b1
    } sofid_e;

endpackage

`default_nettype wire

// ==== ex_issue_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

module ex_issue_reg
    import ex_pkg::*;
    (
        input  wire                         clk_i,
        input  wire                         reset_i,
        input  wire                         stage_en_i,
        // decoder fields
        input  wire                         ids_valid_i,
        input  wire                         ids_cond_i,
        input  wire                         ids_jump_i,
        input  wire                         ids_link_i,
        input  wire zone_e                  ids_zone_i,
        input  wire [`EX_XLEN-1:0]          ids_pc_i,
        input  wire [`EX_INS_SIZE_W-1:0]    ids_ins_size_i,
        input  wire [`EX_XLEN-1:0]          ids_regs2_data_i,
        input  wire [`EX_REG_AW-1:0]        ids_regd_addr_i,
        input  wire [`EX_FUNCT3_W-1:0]      ids_funct3_i,
        // registered fields
        output logic                        valid_o,
        output logic                        cond_o,
        output logic                        jump_o,
        output logic                        link_o,
        output logic                        lq_wr_o,
        output logic                        sq_wr_o,
        output logic                        regd_wr_o,
        output logic [`EX_XLEN-1:0]         pc_inc_o,
        output logic [`EX_XLEN-1:0]         regs2_data_o,
        output logic [`EX_REG_AW-1:0]       regd_addr_o,
        output logic [`EX_FUNCT3_W-1:0]     funct3_o
    );

    logic [`EX_XLEN-1:0] pc_inc;

    // ------------------------------------------------------------
    // link address
    // ------------------------------------------------------------

    // size is in halfwords, so shift left by one for bytes
    assign pc_inc = ids_pc_i +
                    {{(`EX_XLEN-`EX_INS_SIZE_W-1){1'b0}}, ids_ins_size_i, 1'b0};

    // ------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (stage_en_i) begin
            valid_o <= ids_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            cond_o       <= ids_cond_i;
            jump_o       <= ids_jump_i;
            link_o       <= ids_link_i;
            pc_inc_o     <= pc_inc;
            regs2_data_o <= ids_regs2_data_i;
            regd_addr_o  <= ids_regd_addr_i;
            funct3_o     <= ids_funct3_i;
            // zone decode, one hot or none
            lq_wr_o      <= (ids_zone_i == ZONE_LOADQ);
            sq_wr_o      <= (ids_zone_i == ZONE_STOREQ);
            regd_wr_o    <= (ids_zone_i == ZONE_REGFILE);
        end
    end

endmodule

`default_nettype wire

// ==== ex_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

module ex_alu
    import ex_pkg::*;
    (
        input  wire                     clk_i,
        input  wire                     reset_i,
        input  wire                     stage_en_i,
        // arithmetic/logic operands
        input  wire alu_op_e            op_i,
        input  wire [`EX_XLEN-1:0]      op_left_i,
        input  wire [`EX_XLEN-1:0]      op_right_i,
        // branch compare operands
        input  wire cmp_op_e            cmp_op_i,
        input  wire [`EX_XLEN-1:0]      cmp_left_i,
        input  wire [`EX_XLEN-1:0]      cmp_right_i,
        // registered results
        output logic [`EX_XLEN-1:0]     result_o,
        output logic                    cmp_o
    );

    logic [`EX_XLEN-1:0] result;
    logic [4:0]          shamt;
    logic                op_lt;
    logic                op_ltu;
    logic                cmp_eq;
    logic                cmp_lt;
    logic                cmp_ltu;
    logic                cmp;

    // ------------------------------------------------------------
    // arithmetic/logic
    // ------------------------------------------------------------

    // rv32 shifts only look at the low five bits
    assign shamt  = op_right_i[4:0];
    assign op_lt  = $signed(op_left_i) < $signed(op_right_i);
    assign op_ltu = op_left_i < op_right_i;

    always_comb begin
        case (op_i)
            ALU_ADD  : result = op_left_i + op_right_i;
            ALU_SUB  : result = op_left_i - op_right_i;
            ALU_AND  : result = op_left_i & op_right_i;
            ALU_OR   : result = op_left_i | op_right_i;
            ALU_XOR  : result = op_left_i ^ op_right_i;
            ALU_SLL  : result = op_left_i << shamt;
            ALU_SRL  : result = op_left_i >> shamt;
            ALU_SRA  : result = $unsigned($signed(op_left_i) >>> shamt);
            ALU_SLT  : result = {{(`EX_XLEN-1){1'b0}}, op_lt};
            ALU_SLTU : result = {{(`EX_XLEN-1){1'b0}}, op_ltu};
            default  : result = '0;
        endcase
    end

    // ------------------------------------------------------------
    // branch compare
    // ------------------------------------------------------------

    assign cmp_eq  = cmp_left_i == cmp_right_i;
    assign cmp_lt  = $signed(cmp_left_i) < $signed(cmp_right_i);
    assign cmp_ltu = cmp_left_i < cmp_right_i;

    always_comb begin
        case (cmp_op_i)
            CMP_EQ  : cmp = cmp_eq;
            CMP_NE  : cmp = ~cmp_eq;
            CMP_LT  : cmp = cmp_lt;
            CMP_GE  : cmp = ~cmp_lt;
            CMP_LTU : cmp = cmp_ltu;
            CMP_GEU : cmp = ~cmp_ltu;
            // reserved branch codes never take
            default : cmp = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            cmp_o <= 1'b0;
        end else if (stage_en_i) begin
            cmp_o <= cmp;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            result_o <= result;
        end
    end

endmodule

`default_nettype wire

// ==== ex_commit_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

module ex_commit_ctrl
    import ex_pkg::*;
    (
        input  wire                     clk_i,
        input  wire                     reset_i,
        // decoder side, next instruction
        input  wire                     ids_valid_i,
        input  wire sofid_e             ids_sofid_i,
        // instruction in the stage
        input  wire                     valid_i,
        input  wire                     cond_i,
        input  wire                     jump_i,
        input  wire                     link_i,
        input  wire                     lq_wr_i,
        input  wire                     sq_wr_i,
        input  wire                     regd_wr_i,
        input  wire [`EX_XLEN-1:0]      alu_result_i,
        input  wire [`EX_XLEN-1:0]      pc_inc_i,
        input  wire                     cmp_i,
        // queue back-pressure
        input  wire                     lsq_full_i,
        // stage control
        output logic                    stage_en_o,
        output logic                    ids_stall_o,
        // prefetch unit
        output logic                    pfu_jump_o,
        output logic [`EX_XLEN-1:0]     pfu_jump_addr_o,
        // write-back
        output logic                    ids_regd_wr_o,
        output logic                    ids_regd_cncl_load_o,
        output logic [`EX_XLEN-1:0]     ids_regd_data_o,
        // load/store queue
        output logic                    lsq_lq_wr_o,
        output logic                    lsq_sq_wr_o
    );

    sofid_e sofid_q;
    logic   ex_valid;
    logic   commit;
    logic   jump;
    logic   stall;

    // ------------------------------------------------------------
    // commit decision
    // ------------------------------------------------------------

    // instructions on a discarded path never commit
    assign ex_valid = valid_i & (sofid_q == SOFID_RUN);
    assign commit   = ex_valid & (cmp_i | ~cond_i);
    assign jump     = commit & jump_i;

    // ------------------------------------------------------------
    // stall
    // ------------------------------------------------------------

    assign stall       = commit & lsq_full_i & (lq_wr_i | sq_wr_i);
    assign stage_en_o  = ~stall;
    assign ids_stall_o = stall;

    // ------------------------------------------------------------
    // path tracking
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            sofid_q <= SOFID_RUN;
        end else if (stage_en_o) begin
            if (jump) begin
                sofid_q <= SOFID_JUMP;
            end else if (ids_valid_i && sofid_q == SOFID_JUMP &&
                         ids_sofid_i == SOFID_JUMP) begin
                // first fetch from the new path arrives
                sofid_q <= SOFID_RUN;
            end
        end
    end

    // ------------------------------------------------------------
    // strobes
    // ------------------------------------------------------------

    // held high across a stall, one event per instruction
    assign pfu_jump_o           = jump;
    assign pfu_jump_addr_o      = alu_result_i;
    assign ids_regd_wr_o        = commit & regd_wr_i;
    assign ids_regd_cncl_load_o = ~commit & valid_i & lq_wr_i;
    assign lsq_lq_wr_o          = commit & lq_wr_i;
    assign lsq_sq_wr_o          = commit & sq_wr_i;

    // link writes return address instead of the alu result
    always_comb begin
        if (link_i) begin
            ids_regd_data_o = pc_inc_i;
        end else begin
            ids_regd_data_o = alu_result_i;
        end
    end

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

module ex_stage
    import ex_pkg::*;
    (
        input  wire                     clk_i,
        input  wire                     reset_i,
        // decoder
        input  wire                     ids_valid_i,
        input  wire sofid_e             ids_sofid_i,
        input  wire [`EX_INS_SIZE_W-1:0] ids_ins_size_i,
        input  wire                     ids_jump_i,
        input  wire                     ids_cond_i,
        input  wire                     ids_link_i,
        input  wire zone_e              ids_zone_i,
        input  wire [`EX_XLEN-1:0]      ids_pc_i,
        input  wire alu_op_e            ids_alu_op_i,
        input  wire [`EX_XLEN-1:0]      ids_operand_left_i,
        input  wire [`EX_XLEN-1:0]      ids_operand_right_i,
        input  wire cmp_op_e            ids_cmp_op_i,
        input  wire [`EX_XLEN-1:0]      ids_regs1_data_i,
        input  wire [`EX_XLEN-1:0]      ids_cmp_right_i,
        input  wire [`EX_XLEN-1:0]      ids_regs2_data_i,
        input  wire [`EX_REG_AW-1:0]    ids_regd_addr_i,
        input  wire [`EX_FUNCT3_W-1:0]  ids_funct3_i,
        output logic                    ids_stall_o,
        // prefetch unit
        output logic                    pfu_jump_o,
        output logic [`EX_XLEN-1:0]     pfu_jump_addr_o,
        // write-back
        output logic                    ids_regd_wr_o,
        output logic                    ids_regd_cncl_load_o,
        output logic [`EX_REG_AW-1:0]   ids_regd_addr_o,
        output logic [`EX_XLEN-1:0]     ids_regd_data_o,
        // load/store queue
        input  wire                     lsq_full_i,
        output logic                    lsq_lq_wr_o,
        output logic                    lsq_sq_wr_o,
        output logic [`EX_FUNCT3_W-1:0] lsq_funct3_o,
        output logic [`EX_REG_AW-1:0]   lsq_regd_addr_o,
        output logic [`EX_XLEN-1:0]     lsq_regs2_data_o,
        output logic [`EX_XLEN-1:0]     lsq_addr_o
    );

    logic                    stage_en;
    logic                    valid;
    logic                    cond;
    logic                    jump;
    logic                    link;
    logic                    lq_wr;
    logic                    sq_wr;
    logic                    regd_wr;
    logic [`EX_XLEN-1:0]     pc_inc;
    logic [`EX_REG_AW-1:0]   regd_addr;
    logic [`EX_XLEN-1:0]     alu_result;
    logic                    alu_cmp;

    // register address goes to both write-back and queue
    assign ids_regd_addr_o = regd_addr;
    assign lsq_regd_addr_o = regd_addr;
    assign lsq_addr_o      = alu_result;

    ex_issue_reg u_issue_reg (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .stage_en_i       (stage_en),
        .ids_valid_i      (ids_valid_i),
        .ids_cond_i       (ids_cond_i),
        .ids_jump_i       (ids_jump_i),
        .ids_link_i       (ids_link_i),
        .ids_zone_i       (ids_zone_i),
        .ids_pc_i         (ids_pc_i),
        .ids_ins_size_i   (ids_ins_size_i),
        .ids_regs2_data_i (ids_regs2_data_i),
        .ids_regd_addr_i  (ids_regd_addr_i),
        .ids_funct3_i     (ids_funct3_i),
        .valid_o          (valid),
        .cond_o           (cond),
        .jump_o           (jump),
        .link_o           (link),
        .lq_wr_o          (lq_wr),
        .sq_wr_o          (sq_wr),
        .regd_wr_o        (regd_wr),
        .pc_inc_o         (pc_inc),
        .regs2_data_o     (lsq_regs2_data_o),
        .regd_addr_o      (regd_addr),
        .funct3_o         (lsq_funct3_o)
    );

    ex_alu u_alu (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .stage_en_i  (stage_en),
        .op_i        (ids_alu_op_i),
        .op_left_i   (ids_operand_left_i),
        .op_right_i  (ids_operand_right_i),
        .cmp_op_i    (ids_cmp_op_i),
        .cmp_left_i  (ids_regs1_data_i),
        .cmp_right_i (ids_cmp_right_i),
        .result_o    (alu_result),
        .cmp_o       (alu_cmp)
    );

    ex_commit_ctrl u_commit_ctrl (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .ids_valid_i          (ids_valid_i),
        .ids_sofid_i          (ids_sofid_i),
        .valid_i              (valid),
        .cond_i               (cond),
        .jump_i               (jump),
        .link_i               (link),
        .lq_wr_i              (lq_wr),
        .sq_wr_i              (sq_wr),
        .regd_wr_i            (regd_wr),
        .alu_result_i         (alu_result),
        .pc_inc_i             (pc_inc),
        .cmp_i                (alu_cmp),
        .lsq_full_i           (lsq_full_i),
        .stage_en_o           (stage_en),
        .ids_stall_o          (ids_stall_o),
        .pfu_jump_o           (pfu_jump_o),
        .pfu_jump_addr_o      (pfu_jump_addr_o),
        .ids_regd_wr_o        (ids_regd_wr_o),
        .ids_regd_cncl_load_o (ids_regd_cncl_load_o),
        .ids_regd_data_o      (ids_regd_data_o),
        .lsq_lq_wr_o          (lsq_lq_wr_o),
        .lsq_sq_wr_o          (lsq_sq_wr_o)
    );

endmodule

`default_nettype wire

// ==== ex_stage_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage_checker (
        input  wire clk_i,
        input  wire reset_i,
        input  wire lsq_full_i,
        input  wire ids_stall_o,
        input  wire pfu_jump_o,
        input  wire ids_regd_wr_o,
        input  wire ids_regd_cncl_load_o,
        input  wire lsq_lq_wr_o,
        input  wire lsq_sq_wr_o
    );

    // ------------------------------------------------------------
    // protocol properties
    // ------------------------------------------------------------

    // back-pressure is the only stall source
    assert property (@(posedge clk_i) disable iff (reset_i) ids_stall_o |-> lsq_full_i)
        else $error("stall without a full queue");

    // one destination per instruction
    assert property (@(posedge clk_i) disable iff (reset_i)
                     $onehot0({ids_regd_wr_o, lsq_lq_wr_o, lsq_sq_wr_o}))
        else $error("more than one write strobe");

    assert property (@(posedge clk_i) reset_i |-> !(ids_stall_o | pfu_jump_o |
                     ids_regd_wr_o | ids_regd_cncl_load_o | lsq_lq_wr_o | lsq_sq_wr_o))
        else $error("strobe high during reset");

endmodule

bind ex_stage ex_stage_checker u_checker (.*);

`default_nettype wire

// ==== tb_ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ex_defines.svh"

module tb_ex_stage
    import ex_pkg::*;
    ;

    typedef struct {
        alu_op_e                   op;
        zone_e                     zone;
        cmp_op_e                   cmp;
        sofid_e                    tag;
        logic                      valid;
        logic                      cond;
        logic                      jump;
        logic                      link;
        logic                      full;
        logic [`EX_XLEN-1:0]       left;
        logic [`EX_XLEN-1:0]       right;
        logic [`EX_XLEN-1:0]       rs1;
        logic [`EX_XLEN-1:0]       cmp_right;
        logic [`EX_XLEN-1:0]       rs2;
        logic [`EX_XLEN-1:0]       pc;
        logic [`EX_INS_SIZE_W-1:0] size;
        logic [`EX_REG_AW-1:0]     rd;
        logic [`EX_FUNCT3_W-1:0]   funct3;
    } row_t;

    logic                      clk_i;
    logic                      reset_i;
    logic                      ids_valid_i;
    sofid_e                    ids_sofid_i;
    logic [`EX_INS_SIZE_W-1:0] ids_ins_size_i;
    logic                      ids_jump_i;
    logic                      ids_cond_i;
    logic                      ids_link_i;
    zone_e                     ids_zone_i;
    logic [`EX_XLEN-1:0]       ids_pc_i;
    alu_op_e                   ids_alu_op_i;
    logic [`EX_XLEN-1:0]       ids_operand_left_i;
    logic [`EX_XLEN-1:0]       ids_operand_right_i;
    cmp_op_e                   ids_cmp_op_i;
    logic [`EX_XLEN-1:0]       ids_regs1_data_i;
    logic [`EX_XLEN-1:0]       ids_cmp_right_i;
    logic [`EX_XLEN-1:0]       ids_regs2_data_i;
    logic [`EX_REG_AW-1:0]     ids_regd_addr_i;
    logic [`EX_FUNCT3_W-1:0]   ids_funct3_i;
    logic                      lsq_full_i;
    logic                      ids_stall_o;
    logic                      pfu_jump_o;
    logic [`EX_XLEN-1:0]       pfu_jump_addr_o;
    logic                      ids_regd_wr_o;
    logic                      ids_regd_cncl_load_o;
    logic [`EX_REG_AW-1:0]     ids_regd_addr_o;
    logic [`EX_XLEN-1:0]       ids_regd_data_o;
    logic                      lsq_lq_wr_o;
    logic                      lsq_sq_wr_o;
    logic [`EX_FUNCT3_W-1:0]   lsq_funct3_o;
    logic [`EX_REG_AW-1:0]     lsq_regd_addr_o;
    logic [`EX_XLEN-1:0]       lsq_regs2_data_o;
    logic [`EX_XLEN-1:0]       lsq_addr_o;

    row_t        rows[$];
    row_t        prev;
    row_t        next;
    sofid_e      path;
    logic [31:0] seed;
    int          data_errors;
    int          addr_errors;
    int          funct3_errors;
    int          bit_errors;
    int          timeouts;

    ex_stage u_ex_stage (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic logic [`EX_XLEN-1:0] alu_model(alu_op_e op, logic [`EX_XLEN-1:0] a,
                                                     logic [`EX_XLEN-1:0] b);
        case (op)
            ALU_ADD  : return a + b;
            ALU_SUB  : return a - b;
            ALU_AND  : return a & b;
            ALU_OR   : return a | b;
            ALU_XOR  : return a ^ b;
            ALU_SLL  : return a << b[4:0];
            ALU_SRL  : return a >> b[4:0];
            ALU_SRA  : return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT  : return `EX_XLEN'($signed(a) < $signed(b));
            ALU_SLTU : return `EX_XLEN'(a < b);
            default  : return '0;
        endcase
    endfunction

    function automatic logic cmp_model(cmp_op_e op, logic [`EX_XLEN-1:0] a,
                                       logic [`EX_XLEN-1:0] b);
        case (op)
            CMP_EQ  : return a == b;
            CMP_NE  : return a != b;
            CMP_LT  : return $signed(a) < $signed(b);
            CMP_GE  : return $signed(a) >= $signed(b);
            CMP_LTU : return a < b;
            CMP_GEU : return a >= b;
            default : return 1'b0;
        endcase
    endfunction

    function automatic logic commits(row_t r, sofid_e p);
        return r.valid && p == SOFID_RUN && (!r.cond || cmp_model(r.cmp, r.rs1, r.cmp_right));
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------

    task automatic check_data(string name, logic [`EX_XLEN-1:0] exp, logic [`EX_XLEN-1:0] act);
        if (act !== exp) begin
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_addr(string name, logic [`EX_REG_AW-1:0] exp,
                              logic [`EX_REG_AW-1:0] act);
        if (act !== exp) begin
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            addr_errors++;
        end
    endtask

    task automatic check_funct3(string name, logic [`EX_FUNCT3_W-1:0] exp,
                                logic [`EX_FUNCT3_W-1:0] act);
        if (act !== exp) begin
            $display("Fail time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            funct3_errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail time=%0t %s expected=%b actual=%b", $time, name, exp, act);
            bit_errors++;
        end
    endtask

    task automatic add_row(alu_op_e op, zone_e zone, logic cond, logic jump, logic link,
                           cmp_op_e cmp, sofid_e tag, logic full);
        row_t r;
        r.op        = op;
        r.zone      = zone;
        r.cond      = cond;
        r.jump      = jump;
        r.link      = link;
        r.cmp       = cmp;
        r.tag       = tag;
        r.full      = full;
        r.valid     = 1'b1;
        r.left      = lcg_next();
        r.right     = lcg_next();
        r.rs1       = lcg_next();
        r.cmp_right = lcg_next();
        r.rs2       = lcg_next();
        r.pc        = lcg_next() & 32'hffff_fffe;
        r.size      = lcg_next() >= 32'h8000_0000 ? 2'd2 : 2'd1;
        r.rd        = 5'(lcg_next() >> 27);
        r.funct3    = 3'(lcg_next() >> 29);
        rows.push_back(r);
    endtask

    task automatic drive_row(row_t r);
        ids_valid_i         = r.valid;
        ids_sofid_i         = r.tag;
        ids_ins_size_i      = r.size;
        ids_jump_i          = r.jump;
        ids_cond_i          = r.cond;
        ids_link_i          = r.link;
        ids_zone_i          = r.zone;
        ids_pc_i            = r.pc;
        ids_alu_op_i        = r.op;
        ids_operand_left_i  = r.left;
        ids_operand_right_i = r.right;
        ids_cmp_op_i        = r.cmp;
        ids_regs1_data_i    = r.rs1;
        ids_cmp_right_i     = r.cmp_right;
        ids_regs2_data_i    = r.rs2;
        ids_regd_addr_i     = r.rd;
        ids_funct3_i        = r.funct3;
    endtask

    // expected outputs of the instruction now in the stage
    task automatic check_stage(row_t r, logic full_now);
        logic                c;
        logic                ldst;
        logic [`EX_XLEN-1:0] alu;
        logic [`EX_XLEN-1:0] wb;
        c    = commits(r, path);
        ldst = (r.zone == ZONE_LOADQ) || (r.zone == ZONE_STOREQ);
        alu  = alu_model(r.op, r.left, r.right);
        wb   = r.link ? r.pc + (`EX_XLEN'(r.size) << 1) : alu;
        check_bit("ids_stall_o", c && full_now && ldst, ids_stall_o);
        check_bit("ids_regd_wr_o", c && r.zone == ZONE_REGFILE, ids_regd_wr_o);
        check_bit("lsq_lq_wr_o", c && r.zone == ZONE_LOADQ, lsq_lq_wr_o);
        check_bit("lsq_sq_wr_o", c && r.zone == ZONE_STOREQ, lsq_sq_wr_o);
        check_bit("ids_regd_cncl_load_o", r.valid && !c && r.zone == ZONE_LOADQ,
                  ids_regd_cncl_load_o);
        check_bit("pfu_jump_o", c && r.jump, pfu_jump_o);
        if (c && r.jump) begin
            check_data("pfu_jump_addr_o", alu, pfu_jump_addr_o);
        end
        if (c && r.zone == ZONE_REGFILE) begin
            check_data("ids_regd_data_o", wb, ids_regd_data_o);
            check_addr("ids_regd_addr_o", r.rd, ids_regd_addr_o);
        end
        if (c && ldst) begin
            check_data("lsq_addr_o", alu, lsq_addr_o);
            check_data("lsq_regs2_data_o", r.rs2, lsq_regs2_data_o);
            check_addr("lsq_regd_addr_o", r.rd, lsq_regd_addr_o);
            check_funct3("lsq_funct3_o", r.funct3, lsq_funct3_o);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        row_t idle;
        int   wait_cnt;
        seed          = 32'hea5e5c2a;
        data_errors   = 0;
        addr_errors   = 0;
        funct3_errors = 0;
        bit_errors    = 0;
        timeouts      = 0;
        path          = SOFID_RUN;
        reset_i       = 1'b1;
        lsq_full_i    = 1'b0;
        idle          = '{op: ALU_ADD, zone: ZONE_NONE, cmp: CMP_EQ, tag: SOFID_RUN,
                          default: '0};
        drive_row(idle);
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        check_stage(idle, 1'b0);

        // each opcode into the register file
        for (int k = 0; k < 10; k++) begin
            add_row(alu_op_e'(k), ZONE_REGFILE, 0, 0, 0, CMP_EQ, SOFID_RUN, 0);
        end
        // not taken branch, then a taken one and the discarded path
        add_row(ALU_ADD, ZONE_NONE, 1, 1, 0, CMP_EQ, SOFID_RUN, 0);
        add_row(ALU_ADD, ZONE_REGFILE, 0, 0, 0, CMP_EQ, SOFID_RUN, 0);
        add_row(ALU_ADD, ZONE_NONE, 1, 1, 0, CMP_NE, SOFID_RUN, 0);
        add_row(ALU_ADD, ZONE_REGFILE, 0, 0, 0, CMP_EQ, SOFID_RUN, 0);
        add_row(ALU_ADD, ZONE_LOADQ, 0, 0, 0, CMP_EQ, SOFID_RUN, 0);
        add_row(ALU_XOR, ZONE_REGFILE, 0, 0, 0, CMP_EQ, SOFID_JUMP, 0);
        // link jump
        add_row(ALU_ADD, ZONE_REGFILE, 0, 1, 1, CMP_EQ, SOFID_RUN, 0);
        add_row(ALU_SUB, ZONE_STOREQ, 0, 0, 0, CMP_EQ, SOFID_RUN, 0);
        // queue back-pressure
        add_row(ALU_ADD, ZONE_LOADQ, 0, 0, 0, CMP_EQ, SOFID_JUMP, 1);
        add_row(ALU_ADD, ZONE_STOREQ, 0, 0, 0, CMP_EQ, SOFID_RUN, 1);
        add_row(ALU_OR, ZONE_REGFILE, 0, 0, 0, CMP_EQ, SOFID_RUN, 0);

        prev = idle;
        for (int i = 0; i <= rows.size(); i++) begin
            next = (i < rows.size()) ? rows[i] : idle;
            @(negedge clk_i);
            drive_row(next);
            lsq_full_i = prev.full;
            #1;
            check_stage(prev, lsq_full_i);
            wait_cnt = 0;
            while (ids_stall_o && wait_cnt < 20) begin
                @(negedge clk_i);
                lsq_full_i = 1'b0;
                wait_cnt++;
                #1;
                check_stage(prev, lsq_full_i);
            end
            if (ids_stall_o) begin
                $display("stall never released at time %0t", $time);
                timeouts++;
            end
            if (commits(prev, path) && prev.jump) begin
                path = SOFID_JUMP;
            end else if (path == SOFID_JUMP && next.valid && next.tag == SOFID_JUMP) begin
                path = SOFID_RUN;
            end
            prev = next;
        end
        @(negedge clk_i);

        $display("errors: data %0d addr %0d funct3 %0d strobe %0d timeouts %0d",
                 data_errors, addr_errors, funct3_errors, bit_errors, timeouts);
        if (data_errors + addr_errors + funct3_errors + bit_errors + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
ex_pkg.sv
ex_issue_reg.sv
ex_alu.sv
ex_commit_ctrl.sv
ex_stage.sv
ex_stage_checker.sv
tb_ex_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
